/* src/maze_pkg.sv */
package maze_pkg;

    // Tile grid coordinate widths, 32 by 16 tiles at most
    localparam int x_bits = 5;
    localparam int y_bits = 4;

    // One tile of the maze
    typedef struct packed {
        logic [x_bits-1:0] x;
        logic [y_bits-1:0] y;
    } cell_t;

    // Player direction decoded from the keyboard
    typedef enum logic [2:0] {
        dir_none  = 3'd0,
        dir_up    = 3'd1,
        dir_left  = 3'd2,
        dir_down  = 3'd3,
        dir_right = 3'd4
    } dir_e;

    // PS/2 set 2 make codes for W, A, S, D
    localparam logic [7:0] key_up    = 8'h1D;
    localparam logic [7:0] key_left  = 8'h1C;
    localparam logic [7:0] key_down  = 8'h1B;
    localparam logic [7:0] key_right = 8'h23;

    // Pillar pattern
    // a wall sits wherever both coordinates are odd, so every even row and
    // column stays an open corridor
    function automatic logic is_wall(cell_t c);
        return c.x[0] & c.y[0];
    endfunction

endpackage

/* src/step_if.sv */
`timescale 1ns/1ps

interface step_if;
    import maze_pkg::*;

    logic  valid;
    logic  ready;
    dir_e  dir;          // Decoded key
    cell_t player;       // Player cell, moved once past player_move
    cell_t prev_player;  // Player cell before the move
    cell_t ghost;        // Ghost cell, moved once past ghost_chase
    cell_t ghost_prev;   // Ghost cell before the chase
    logic  collided;     // Catch flag carried down the chain

    modport source (
        output valid, dir, player, prev_player, ghost, ghost_prev, collided,
        input  ready
    );

    modport sink (
        input  valid, dir, player, prev_player, ghost, ghost_prev, collided,
        output ready
    );

endinterface

/* src/step_decode.sv */
`timescale 1ns/1ps

module step_decode (
    input  logic            clock,
    input  logic            resetn,
    input  logic            in_valid,
    output logic            in_ready,
    input  logic [7:0]      key,
    input  maze_pkg::cell_t player,
    input  maze_pkg::cell_t ghost,
    step_if.source          down
);
    import maze_pkg::*;

    dir_e key_dir;

    // Anything other than WASD leaves the player where it is
    always_comb begin
        case (key)
            key_up:    key_dir = dir_up;
            key_left:  key_dir = dir_left;
            key_down:  key_dir = dir_down;
            key_right: key_dir = dir_right;
            default:   key_dir = dir_none;
        endcase
    end

    // Slot free or draining this cycle
    assign in_ready = !down.valid || down.ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            down.valid <= 1'b0;
        end else if (in_ready) begin
            down.valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            down.dir         <= key_dir;
            down.player      <= player;
            down.prev_player <= player;  // Kept for the swap test
            down.ghost       <= ghost;
            down.ghost_prev  <= ghost;   // Rewritten by ghost_chase
            down.collided    <= 1'b0;
        end
    end

    // A stalled item must not change under the next stage
    a_hold_stable: assert property (@(posedge clock) disable iff (!resetn)
        down.valid && !down.ready |=> down.valid && $stable(down.dir) &&
            $stable(down.player) && $stable(down.ghost)
    );

endmodule

/* src/player_move.sv */
`timescale 1ns/1ps

module player_move #(
    parameter int grid_w = 32,
    parameter int grid_h = 16
) (
    input  logic   clock,
    input  logic   resetn,
    step_if.sink   up,
    step_if.source down
);
    import maze_pkg::*;

    cell_t target;
    logic  off_grid;
    cell_t next_player;

    // Candidate cell one step in the requested direction
    always_comb begin
        target   = up.player;
        off_grid = 1'b0;
        case (up.dir)
            dir_up: begin
                off_grid = (up.player.y == '0);
                target.y = up.player.y - 1'b1;
            end
            dir_down: begin
                off_grid = (int'(up.player.y) + 1 >= grid_h);
                target.y = up.player.y + 1'b1;
            end
            dir_left: begin
                off_grid = (up.player.x == '0);
                target.x = up.player.x - 1'b1;
            end
            dir_right: begin
                off_grid = (int'(up.player.x) + 1 >= grid_w);
                target.x = up.player.x + 1'b1;
            end
            default: target = up.player;  // No key, no move
        endcase
        next_player = (off_grid || is_wall(target)) ? up.player : target;
    end

    assign up.ready = !down.valid || down.ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            down.valid <= 1'b0;
        end else if (up.ready) begin
            down.valid <= up.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (up.valid && up.ready) begin
            down.dir         <= up.dir;
            down.player      <= next_player;
            down.prev_player <= up.prev_player;
            down.ghost       <= up.ghost;
            down.ghost_prev  <= up.ghost_prev;
            down.collided    <= up.collided;
        end
    end

    a_player_open: assert property (@(posedge clock) disable iff (!resetn)
        down.valid && down.ready |-> !is_wall(down.player)
    );

endmodule

/* src/ghost_chase.sv */
`timescale 1ns/1ps

module ghost_chase #(
    parameter int grid_w = 32,
    parameter int grid_h = 16
) (
    input  logic   clock,
    input  logic   resetn,
    step_if.sink   up,
    step_if.source down
);
    import maze_pkg::*;

    logic [x_bits-1:0] dist_x;
    logic [y_bits-1:0] dist_y;
    cell_t             step_x;  // One tile toward the player along x
    cell_t             step_y;  // Same along y
    logic              x_first;
    cell_t             next_ghost;

    function automatic logic open_cell(cell_t c);
        return !is_wall(c) && int'(c.x) < grid_w && int'(c.y) < grid_h;
    endfunction

    // Manhattan distance between two cells
    function automatic int cell_gap(cell_t a, cell_t b);
        int gx;
        int gy;
        gx = int'(a.x) - int'(b.x);
        gy = int'(a.y) - int'(b.y);
        if (gx < 0) begin
            gx = -gx;
        end
        if (gy < 0) begin
            gy = -gy;
        end
        return gx + gy;
    endfunction

    always_comb begin
        step_x = up.ghost;
        step_y = up.ghost;
        if (up.player.x > up.ghost.x) begin
            dist_x   = up.player.x - up.ghost.x;
            step_x.x = up.ghost.x + 1'b1;
        end else begin
            dist_x   = up.ghost.x - up.player.x;
            step_x.x = up.ghost.x - 1'b1;  // Unused when dist_x is zero
        end
        if (up.player.y > up.ghost.y) begin
            dist_y   = up.player.y - up.ghost.y;
            step_y.y = up.ghost.y + 1'b1;
        end else begin
            dist_y   = up.ghost.y - up.player.y;
            step_y.y = up.ghost.y - 1'b1;
        end
        x_first = int'(dist_x) >= int'(dist_y);  // Tie goes to x

        next_ghost = up.ghost;
        if (dist_x == '0 && dist_y == '0) begin
            next_ghost = up.ghost;  // Already on the player
        end else if (x_first) begin
            if (open_cell(step_x)) begin
                next_ghost = step_x;
            end else if (dist_y != '0 && open_cell(step_y)) begin
                next_ghost = step_y;
            end
        end else begin
            if (open_cell(step_y)) begin
                next_ghost = step_y;
            end else if (dist_x != '0 && open_cell(step_x)) begin
                next_ghost = step_x;
            end
        end
    end

    assign up.ready = !down.valid || down.ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            down.valid <= 1'b0;
        end else if (up.ready) begin
            down.valid <= up.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (up.valid && up.ready) begin
            down.dir         <= up.dir;
            down.player      <= up.player;
            down.prev_player <= up.prev_player;
            down.ghost       <= next_ghost;
            down.ghost_prev  <= up.ghost;
            down.collided    <= up.collided;
        end
    end

    // Ghost never jumps more than one tile per frame
    a_ghost_step: assert property (@(posedge clock) disable iff (!resetn)
        up.valid && up.ready |=> cell_gap(down.ghost, $past(up.ghost)) <= 1
    );

endmodule

/* src/collision_check.sv */
`timescale 1ns/1ps

module collision_check (
    input  logic            clock,
    input  logic            resetn,
    step_if.sink            up,
    output logic            out_valid,
    input  logic            out_ready,
    output maze_pkg::cell_t player,
    output maze_pkg::cell_t ghost,
    output logic            collided
);
    import maze_pkg::*;

    logic same_cell;
    logic swapped;

    assign same_cell = (up.player == up.ghost);
    // Passed through each other during the move
    assign swapped   = (up.ghost == up.prev_player) && (up.player == up.ghost_prev);

    assign up.ready = !out_valid || out_ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
        end else if (up.ready) begin
            out_valid <= up.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (up.valid && up.ready) begin
            player   <= up.player;
            ghost    <= up.ghost;
            collided <= up.collided || same_cell || swapped;
        end
    end

    a_no_wall_out: assert property (@(posedge clock) disable iff (!resetn)
        out_valid |-> !is_wall(player) && !is_wall(ghost)
    );

endmodule

/* src/maze_step.sv */
`timescale 1ns/1ps

module maze_step #(
    parameter int grid_w = 32,
    parameter int grid_h = 16
) (
    input  logic                        clock,
    input  logic                        resetn,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [7:0]                  key,
    input  logic [maze_pkg::x_bits-1:0] player_x,
    input  logic [maze_pkg::y_bits-1:0] player_y,
    input  logic [maze_pkg::x_bits-1:0] ghost_x,
    input  logic [maze_pkg::y_bits-1:0] ghost_y,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [maze_pkg::x_bits-1:0] new_player_x,
    output logic [maze_pkg::y_bits-1:0] new_player_y,
    output logic [maze_pkg::x_bits-1:0] new_ghost_x,
    output logic [maze_pkg::y_bits-1:0] new_ghost_y,
    output logic                        collided
);
    import maze_pkg::*;

    cell_t in_player;
    cell_t in_ghost;
    cell_t out_player;
    cell_t out_ghost;

    assign in_player = '{x: player_x, y: player_y};
    assign in_ghost  = '{x: ghost_x, y: ghost_y};

    assign new_player_x = out_player.x;
    assign new_player_y = out_player.y;
    assign new_ghost_x  = out_ghost.x;
    assign new_ghost_y  = out_ghost.y;

    // Links between the four register slots
    step_if s_dec ();
    step_if s_move ();
    step_if s_chase ();

    step_decode u_decode (
        .clock    (clock),
        .resetn   (resetn),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .key      (key),
        .player   (in_player),
        .ghost    (in_ghost),
        .down     (s_dec.source)
    );

    player_move #(
        .grid_w (grid_w),
        .grid_h (grid_h)
    ) u_move (
        .clock  (clock),
        .resetn (resetn),
        .up     (s_dec.sink),
        .down   (s_move.source)
    );

    ghost_chase #(
        .grid_w (grid_w),
        .grid_h (grid_h)
    ) u_chase (
        .clock  (clock),
        .resetn (resetn),
        .up     (s_move.sink),
        .down   (s_chase.source)
    );

    collision_check u_check (
        .clock     (clock),
        .resetn    (resetn),
        .up        (s_chase.sink),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .player    (out_player),
        .ghost     (out_ghost),
        .collided  (collided)
    );

endmodule

/* tests/tb_maze_step.sv */
`timescale 1ns/1ps

module tb_maze_step;

    localparam int period = 8;

    logic       clock;
    logic       resetn;
    logic       in_valid;
    logic       in_ready;
    logic [7:0] key;
    logic [4:0] player_x;
    logic [3:0] player_y;
    logic [4:0] ghost_x;
    logic [3:0] ghost_y;
    logic       out_valid;
    logic       out_ready;
    logic [4:0] new_player_x;
    logic [3:0] new_player_y;
    logic [4:0] new_ghost_x;
    logic [3:0] new_ghost_y;
    logic       collided;

    // One line of the vector file
    typedef struct packed {
        logic [7:0] key;
        logic [4:0] px;
        logic [3:0] py;
        logic [4:0] gx;
        logic [3:0] gy;
        logic [4:0] epx;
        logic [3:0] epy;
        logic [4:0] egx;
        logic [3:0] egy;
        logic       ecol;
    } vec_t;

    vec_t vecs[$];
    int   pending[$];   // Accepted, result not yet seen
    int   errors;
    int   seed;
    int   cycle;
    int   cycle_limit;
    int   idx;
    int   n_out;
    int   first_accept;
    logic loaded;
    logic took;

    maze_step #(
        .grid_w (32),
        .grid_h (16)
    ) u_dut (
        .clock        (clock),
        .resetn       (resetn),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .key          (key),
        .player_x     (player_x),
        .player_y     (player_y),
        .ghost_x      (ghost_x),
        .ghost_y      (ghost_y),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .new_player_x (new_player_x),
        .new_player_y (new_player_y),
        .new_ghost_x  (new_ghost_x),
        .new_ghost_y  (new_ghost_y),
        .collided     (collided)
    );

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    task automatic load_vectors();
        int    fd;
        int    n;
        int    f[10];
        string line;
        vec_t  v;
        fd = $fopen("tests/step_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/step_vectors.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines match no fields
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
            if (n == 10) begin
                v.key  = 8'(f[0]);
                v.px   = 5'(f[1]);
                v.py   = 4'(f[2]);
                v.gx   = 5'(f[3]);
                v.gy   = 4'(f[4]);
                v.epx  = 5'(f[5]);
                v.epy  = 4'(f[6]);
                v.egx  = 5'(f[7]);
                v.egy  = 4'(f[8]);
                v.ecol = 1'(f[9]);
                vecs.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_vector(vec_t v);
        key      = v.key;
        player_x = v.px;
        player_y = v.py;
        ghost_x  = v.gx;
        ghost_y  = v.gy;
    endtask

    task automatic check_result(int n);
        vec_t v;
        v = vecs[n];
        assert (new_player_x === v.epx) else begin
            $display("FAILED new_player_x vector %0d expected %h got %h", n, v.epx, new_player_x);
            errors++;
        end
        assert (new_player_y === v.epy) else begin
            $display("FAILED new_player_y vector %0d expected %h got %h", n, v.epy, new_player_y);
            errors++;
        end
        assert (new_ghost_x === v.egx) else begin
            $display("FAILED new_ghost_x vector %0d expected %h got %h", n, v.egx, new_ghost_x);
            errors++;
        end
        assert (new_ghost_y === v.egy) else begin
            $display("FAILED new_ghost_y vector %0d expected %h got %h", n, v.egy, new_ghost_y);
            errors++;
        end
        assert (collided === v.ecol) else begin
            $display("FAILED collided vector %0d expected %h got %h", n, v.ecol, collided);
            errors++;
        end
    endtask

    initial begin
        errors       = 0;
        seed         = 63;
        cycle        = 0;
        idx          = 0;
        n_out        = 0;
        first_accept = 0;
        took         = 1'b0;
        loaded       = 1'b0;
        resetn       = 1'b0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        key          = 8'h00;
        player_x     = '0;
        player_y     = '0;
        ghost_x      = '0;
        ghost_y      = '0;
        load_vectors();
        assert (vecs.size() > 0) else begin
            $display("no vectors were read");
            errors++;
        end
        cycle_limit = 20 * vecs.size() + 100;
        loaded = 1'b1;

        repeat (8) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;
        #2;
        assert (in_ready === 1'b1 && out_valid === 1'b0) else begin
            $display("in_ready low or out_valid high after reset");
            errors++;
        end

        while (n_out < vecs.size()) begin
            @(negedge clock);
            cycle++;
            // Full speed until the first result, then random stalls and gaps
            out_ready = (n_out == 0) ? 1'b1 : (($random(seed) & 3) != 0);
            if (took || !in_valid) begin
                took = 1'b0;
                if (idx < vecs.size() && (n_out == 0 || ($random(seed) & 3) != 0)) begin
                    apply_vector(vecs[idx]);
                    in_valid = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            #2;  // Let everything settle before sampling
            if (out_valid && out_ready) begin
                assert (pending.size() > 0) else begin
                    $display("a result appeared with no request outstanding");
                    errors++;
                end
                if (pending.size() > 0) begin
                    // Four register slots between the offer and the result
                    if (n_out == 0) begin
                        assert (cycle - first_accept == 4) else begin
                            $display("first result came %0d cycles after the request, not 4",
                                cycle - first_accept);
                            errors++;
                        end
                    end
                    check_result(pending.pop_front());
                end
                n_out++;
            end
            if (in_valid && in_ready) begin
                if (idx == 0) begin
                    first_accept = cycle;
                end
                pending.push_back(idx);
                idx++;
                took = 1'b1;
            end
        end

        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (6) begin
            @(negedge clock);
            #2;
            assert (out_valid !== 1'b1) else begin
                $display("an extra result appeared after the last vector");
                errors++;
            end
        end

        $display("vectors %0d, results %0d, errors %0d", vecs.size(), n_out, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded === 1'b1);
        repeat (cycle_limit) @(posedge clock);
        $display("timeout after %0d cycles, results %0d of %0d, errors %0d",
            cycle_limit, n_out, vecs.size(), errors);
        $display("sim failed");
        $finish;
    end

endmodule

/* tests/step_vectors.txt */
# key player_x player_y ghost_x ghost_y, then expected
# new_player_x new_player_y new_ghost_x new_ghost_y collided, all hex
# Free moves and unknown keys
1D 04 04 0A 04 04 03 09 04 0
1C 04 04 0A 0A 03 04 09 0A 0
1B 04 04 04 0A 04 05 04 09 0
23 04 04 00 00 05 04 01 00 0
29 06 06 06 0C 06 06 06 0B 0
23 00 00 1E 0F 01 00 1E 0E 0
1D 1E 0F 00 00 1E 0E 01 00 0
# Grid edges and pillars
1D 06 00 14 00 06 00 13 00 0
1C 00 05 00 0C 00 05 00 0B 0
1B 08 0F 08 02 08 0F 08 03 0
23 1F 04 1F 0A 1F 04 1F 0A 0
1D 03 04 0C 04 03 04 0B 04 0
1C 04 03 04 0E 04 03 04 0D 0
1B 05 02 05 0C 05 02 05 0C 0
23 06 07 14 07 06 07 14 07 0
# Chase, tie on x, fallback to the other axis
00 0A 0A 06 06 0A 0A 07 06 0
00 0A 0A 06 07 0A 0A 06 08 0
00 02 02 04 09 02 02 04 08 0
00 02 02 03 0A 02 02 02 0A 0
1B 08 08 08 0E 08 09 08 0D 0
00 14 0C 0E 04 14 0C 0E 05 0
# Catches and near misses
23 0B 06 0C 06 0C 06 0C 06 1
00 0A 04 0B 04 0A 04 0A 04 1
00 04 04 04 06 04 04 04 05 0
23 06 04 06 06 07 04 06 05 0
1B 08 04 08 06 08 05 08 05 1
29 02 08 02 08 02 08 02 08 1

/* flist.f */
src/maze_pkg.sv
src/step_if.sv
src/step_decode.sv
src/player_move.sv
src/ghost_chase.sv
src/collision_check.sv
src/maze_step.sv
tests/tb_maze_step.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_maze_step
FLIST      = flist.f
BUILD_DIR  = obj_dir
LINT_FLAGS = --lint-only --timing -Wno-fatal
SIM_FLAGS  = --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)
